// ==== build.f ====
+incdir+testbench
hw/synth_pkg.sv
hw/voice_ctrl.sv
hw/custom_wave_generator.sv
hw/voice_mixer.sv
hw/wave_synth_top.sv
testbench/wave_synth_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e

cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert \
    --top-module wave_synth_tb \
    -f build.f \
    -o wave_synth_sim

# the log decides the result, not the simulator exit status
./obj_dir/wave_synth_sim | tee "$LOG"

if grep -qx "TESTS PASSED" "$LOG"; then
    exit 0
else
    echo "simulation failed, see $LOG"
    exit 1
fi

// ==== testbench/wave_synth_vectors.svh ====
`ifndef WAVE_SYNTH_VECTORS_SVH
`define WAVE_SYNTH_VECTORS_SVH

// each row holds an op, a host address, a data word and a count
// the data word is the ramp base for fills
// count is cycles for a run and entries for a fill

typedef enum logic [1:0] {
    OP_WRITE,
    OP_RUN,
    OP_RAMP,
    OP_RAND
} op_e;

typedef struct packed {
    op_e         op;
    bus_addr_t   addr;
    bus_data_t   data;
    logic [15:0] count;
} vec_t;

vec_t vecs [$];

// one table index per cycle
localparam bus_data_t STEP_ONE  = 32'h0040_0000;
localparam bus_data_t RUN_START = 32'd3;
localparam bus_data_t STOP      = 32'd0;

// region, voice and table address into one host address
function automatic bus_addr_t addr_of(region_e r, int voice, int ta);
    return {r, voice[2:0], ta[10:0]};
endfunction

task automatic add_vector(op_e op, bus_addr_t a, bus_data_t d, int n);
    vecs.push_back(vec_t'{op, a, d, 16'(n)});
endtask

task automatic load_vectors();
    bus_data_t mixed_base [4] = '{32'h3000, 32'hf000, 32'h0800, 32'hfc00};
    // random samples in both tables of every voice
    for (int v = 0; v < 4; v++) begin
        add_vector(OP_RAND, addr_of(REGION_TABLE, v, 'h000), '0, 1024);
        add_vector(OP_RAND, addr_of(REGION_TABLE, v, 'h400), '0, 1024);
    end
    // voice 0 alone through its first wrap
    add_vector(OP_WRITE, addr_of(REGION_STEP, 0, 0), STEP_ONE, 0);
    add_vector(OP_WRITE, addr_of(REGION_CTRL, 0, 0), RUN_START, 0);
    add_vector(OP_RUN, '0, '0, 1030);
    // refill idle table 1 while table 2 plays
    add_vector(OP_RAMP, addr_of(REGION_TABLE, 0, 'h000), 32'h0000_0100, 256);
    // second wrap plays the new data
    // third wrap leaves table 2 active for the restart
    add_vector(OP_RUN, '0, '0, 1800);
    // mute and then restart from index 0 and table 1
    add_vector(OP_WRITE, addr_of(REGION_CTRL, 0, 0), STOP, 0);
    add_vector(OP_RUN, '0, '0, 20);
    add_vector(OP_WRITE, addr_of(REGION_CTRL, 0, 0), RUN_START, 0);
    add_vector(OP_RUN, '0, '0, 40);
    // voices 4 to 7 do not exist
    add_vector(OP_WRITE, addr_of(REGION_CTRL, 5, 0), RUN_START, 0);
    add_vector(OP_WRITE, addr_of(REGION_STEP, 6, 0), STEP_ONE, 0);
    add_vector(OP_WRITE, addr_of(REGION_TABLE, 7, 0), 32'h0000_7fff, 0);
    add_vector(OP_WRITE, addr_of(REGION_CTRL, 4, 0), 32'd1, 0);
    add_vector(OP_RUN, '0, '0, 20);
    // four voices clamp high, sum exactly, then clamp low after the wrap
    add_vector(OP_WRITE, addr_of(REGION_CTRL, 0, 0), STOP, 0);
    for (int v = 0; v < 4; v++) begin
        add_vector(OP_RAMP, addr_of(REGION_TABLE, v, 'h000), 32'h0000_5000, 64);
        add_vector(OP_RAMP, addr_of(REGION_TABLE, v, 'h040), mixed_base[v], 64);
        add_vector(OP_RAMP, addr_of(REGION_TABLE, v, 'h400), 32'h0000_b000, 64);
    end
    for (int v = 1; v < 4; v++) begin
        add_vector(OP_WRITE, addr_of(REGION_STEP, v, 0), STEP_ONE, 0);
    end
    for (int v = 0; v < 4; v++) begin
        add_vector(OP_WRITE, addr_of(REGION_CTRL, v, 0), RUN_START, 0);
    end
    add_vector(OP_RUN, '0, '0, 1100);
endtask

`endif

// ==== testbench/wave_synth_tb.sv ====
`timescale 1ns/1ps

module wave_synth_tb
    import synth_pkg::*;
();

    localparam int NV = 4;

    logic            clk_i;
    logic            rst_n_i;
    logic            wr_i;
    bus_addr_t       addr_i;
    bus_data_t       data_i;
    logic [NV-1:0]   active_o;
    sample_t         mix_o;

    `include "wave_synth_vectors.svh"

    wave_synth_top #(
        .NUM_VOICES (NV)
    ) dut_i (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .wr_i     (wr_i),
        .addr_i   (addr_i),
        .data_i   (data_i),
        .active_o (active_o),
        .mix_o    (mix_o)
    );

    // ==========================================================================
    // reference model state
    // ==========================================================================

    // controller outputs
    phase_t        m_step [NV];
    logic [NV-1:0] m_en;
    logic [NV-1:0] m_wr;
    logic [NV-1:0] m_start;
    tab_addr_t     m_taddr;
    sample_t       m_pcm;
    // voices
    phase_t        m_phase [NV];
    tab_idx_t      m_prev [NV];
    logic [NV-1:0] m_act;
    sample_t       m_wave [NV];
    sample_t       m_tab [NV][2][1024];
    sample_t       m_mix;

    int            mix_errs;
    int            act_errs;
    int            other_errs;
    int            sat_hi;
    int            sat_lo;
    int            cycles;
    int            limit;
    logic [31:0]   rng;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // one rising edge of the model with registers updated in dependency order
    task automatic model_tick();
        int       sum;
        tab_idx_t idx;
        region_e  region;
        int       voice;
        logic     hit;
        sum = 0;
        // mixer sees the samples of the previous cycle
        for (int v = 0; v < NV; v++) begin
            sum += int'(m_wave[v]);
        end
        if (sum > 32767) begin
            m_mix = 16'sh7fff;
        end else if (sum < -32768) begin
            m_mix = 16'sh8000;
        end else begin
            m_mix = sample_t'(sum);
        end
        for (int v = 0; v < NV; v++) begin
            idx = m_phase[v][31:22];
            m_wave[v] = m_en[v] ? m_tab[v][m_act[v]][idx] : sample_t'(0);
            if (m_start[v]) begin
                m_phase[v] = '0;
                m_prev[v]  = '0;
                m_act[v]   = 1'b0;
            end else begin
                // index fell so the phase wrapped
                if (idx < m_prev[v]) begin
                    m_act[v] = ~m_act[v];
                end
                m_prev[v] = idx;
                if (m_en[v]) begin
                    m_phase[v] = m_phase[v] + m_step[v];
                end
            end
            if (m_wr[v]) begin
                m_tab[v][m_taddr[10]][m_taddr[9:0]] = m_pcm;
            end
        end
        // host decode with bits 15..14 as region and 13..11 as voice
        region = region_e'(addr_i[15:14]);
        voice  = int'(addr_i[13:11]);
        hit    = wr_i && (voice < NV);
        for (int v = 0; v < NV; v++) begin
            m_wr[v]    = hit && voice == v && region == REGION_TABLE;
            m_start[v] = hit && voice == v && region == REGION_CTRL && data_i[1];
            if (hit && voice == v && region == REGION_STEP) begin
                m_step[v] = data_i;
            end
            if (hit && voice == v && region == REGION_CTRL) begin
                m_en[v] = data_i[0];
            end
        end
        if (hit && region == REGION_TABLE) begin
            m_taddr = addr_i[10:0];
            m_pcm   = sample_t'(data_i[15:0]);
        end
    endtask

    task automatic check_outputs();
        assert (mix_o === m_mix) else begin
            mix_errs++;
            $display("mismatch at %0t: mix_o %0d, expected %0d", $time, mix_o, m_mix);
        end
        assert (active_o === m_act) else begin
            act_errs++;
            $display("mismatch at %0t: active_o %b, expected %b", $time, active_o, m_act);
        end
        if (m_mix == 16'sh7fff) begin
            sat_hi++;
        end
        if (m_mix == 16'sh8000) begin
            sat_lo++;
        end
    endtask

    // ==========================================================================
    // stimulus
    // ==========================================================================

    // inputs change and outputs are checked on the falling edge
    task automatic clock_cycle();
        @(posedge clk_i);
        model_tick();
        @(negedge clk_i);
        check_outputs();
    endtask

    task automatic host_write(input bus_addr_t a, input bus_data_t d);
        wr_i   = 1'b1;
        addr_i = a;
        data_i = d;
        clock_cycle();
        wr_i   = 1'b0;
        addr_i = '0;
        data_i = '0;
    endtask

    task automatic apply_vector(input vec_t e);
        bus_addr_t a;
        case (e.op)
            OP_WRITE: host_write(e.addr, e.data);
            OP_RUN: begin
                repeat (int'(e.count)) clock_cycle();
            end
            OP_RAMP: begin
                // value follows the full 11-bit table address
                for (int i = 0; i < int'(e.count); i++) begin
                    a = e.addr + bus_addr_t'(i);
                    host_write(a, e.data + bus_data_t'(a[10:0]));
                end
            end
            default: begin
                for (int i = 0; i < int'(e.count); i++) begin
                    a   = e.addr + bus_addr_t'(i);
                    rng = xorshift(rng);
                    host_write(a, {16'h0000, rng[15:0]});
                end
            end
        endcase
    endtask

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    // run limit
    always @(posedge clk_i) begin
        cycles++;
        if (limit > 0 && cycles > limit) begin
            $display("timeout: stimulus still running after %0d cycles", limit);
            $display("TESTS FAILED");
            $finish;
        end
    end

    initial begin
        rst_n_i = 1'b0;
        wr_i    = 1'b0;
        addr_i  = '0;
        data_i  = '0;
        rng     = 32'd92;
        cycles  = 0;
        limit   = 0;
        for (int v = 0; v < NV; v++) begin
            m_step[v]  = '0;
            m_phase[v] = '0;
            m_prev[v]  = '0;
            m_wave[v]  = '0;
        end
        m_en    = '0;
        m_wr    = '0;
        m_start = '0;
        m_act   = '0;
        m_taddr = '0;
        m_pcm   = '0;
        m_mix   = '0;
        load_vectors();
        // runs plus writes plus margin
        limit = 50;
        foreach (vecs[i]) begin
            limit += (vecs[i].op == OP_WRITE) ? 1 : int'(vecs[i].count);
        end
        // two rising edges in reset, release on the falling edge after them
        repeat (2) @(posedge clk_i);
        @(negedge clk_i);
        rst_n_i = 1'b1;
        foreach (vecs[i]) begin
            apply_vector(vecs[i]);
        end
        assert (sat_hi > 0) else begin
            other_errs++;
            $display("the mix never clamped at the positive limit");
        end
        assert (sat_lo > 0) else begin
            other_errs++;
            $display("the mix never clamped at the negative limit");
        end
        $display("errors: mix %0d, active %0d, other %0d", mix_errs, act_errs, other_errs);
        if (mix_errs + act_errs + other_errs == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule : wave_synth_tb

// ==== hw/wave_synth_top.sv ====
`timescale 1ns/1ps

module wave_synth_top
    import synth_pkg::*;
#(
    parameter int NUM_VOICES = 4
) (
    input  logic                  clk_i,
    input  logic                  rst_n_i,

    // host write port
    input  logic                  wr_i,
    input  bus_addr_t             addr_i,
    input  bus_data_t             data_i,

    // active table per voice
    output logic [NUM_VOICES-1:0] active_o,

    // mixed pcm stream
    output sample_t               mix_o
);

    // ==========================================================================
    // internal buses
    // ==========================================================================

    voice_cmd_t cmd  [NUM_VOICES];
    sample_t    wave [NUM_VOICES];

    // host decode, one cycle
    voice_ctrl #(
        .NUM_VOICES (NUM_VOICES)
    ) u_ctrl (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .wr_i    (wr_i),
        .addr_i  (addr_i),
        .data_i  (data_i),
        .cmd_o   (cmd)
    );

    // ==========================================================================
    // voices
    // ==========================================================================

    for (genvar v = 0; v < NUM_VOICES; v++) begin : g_voice
        custom_wave_generator u_voice (
            .clk_i          (clk_i),
            .rst_n_i        (rst_n_i),
            .cmd_i          (cmd[v]),
            .active_table_o (active_o[v]),
            .wave_o         (wave[v])
        );
    end : g_voice

    // registered saturating sum
    voice_mixer #(
        .NUM_VOICES (NUM_VOICES)
    ) u_mixer (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .wave_i  (wave),
        .mix_o   (mix_o)
    );

endmodule : wave_synth_top

// ==== hw/voice_mixer.sv ====
`timescale 1ns/1ps

module voice_mixer
    import synth_pkg::*;
#(
    parameter int NUM_VOICES = 4
) (
    input  logic    clk_i,
    input  logic    rst_n_i,

    // one sample per voice
    input  sample_t wave_i [NUM_VOICES],

    // saturated mix
    output sample_t mix_o
);

    // ==========================================================================
    // wide sum
    // ==========================================================================

    // headroom for the largest voice count
    localparam int SUM_W  = $bits(sample_t) + $clog2(MAX_VOICES);
    localparam int SMP_W  = $bits(sample_t);

    typedef logic signed [SUM_W-1:0] sum_t;

    // clamp limits in sum width
    localparam sum_t SUM_MAX = sum_t'(32767);
    localparam sum_t SUM_MIN = -sum_t'(32768);

    sum_t    sum;
    sample_t clamped;

    always_comb begin
        sum_t ext;
        sum = '0;
        ext = '0;
        for (int i = 0; i < NUM_VOICES; i++) begin
            // sign extension of each voice
            ext = sum_t'({{(SUM_W-SMP_W){wave_i[i][SMP_W-1]}}, wave_i[i]});
            sum = sum + ext;
        end
    end

    // ==========================================================================
    // saturation and output register
    // ==========================================================================

    always_comb begin
        if (sum > SUM_MAX) begin
            clamped = 16'sh7fff;
        end else if (sum < SUM_MIN) begin
            clamped = 16'sh8000;
        end else begin
            // in range, low bits are exact
            clamped = sample_t'(sum[SMP_W-1:0]);
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mix_o <= '0;
        end else begin
            mix_o <= clamped;
        end
    end

    // clamping keeps the sign of the wide sum
    a_sign_kept : assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        mix_o[SMP_W-1] == $past(sum[SUM_W-1])
    );

endmodule : voice_mixer

// ==== hw/custom_wave_generator.sv ====
`timescale 1ns/1ps

module custom_wave_generator
    import synth_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_n_i,

    // commands from the controller
    input  voice_cmd_t cmd_i,

    // table currently played
    output logic       active_table_o,

    // pcm out
    output sample_t    wave_o
);

    // ==========================================================================
    // phase accumulator
    // ==========================================================================

    phase_t   phase_q;
    tab_idx_t idx;
    tab_idx_t idx_prev_q;

    // top phase bits address the table
    assign idx = phase_q[$bits(phase_t)-1 -: $bits(tab_idx_t)];

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            phase_q <= '0;
        end else if (cmd_i.start) begin
            // restart from the top of the table
            phase_q <= '0;
        end else if (cmd_i.enable) begin
            phase_q <= phase_q + cmd_i.inc_step;
        end
    end

    // ==========================================================================
    // table swap control
    // ==========================================================================

    logic active_q;

    // previous index tracks every cycle
    // so a paused voice never sees a false wrap
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            idx_prev_q <= '0;
            active_q   <= 1'b0;
        end else if (cmd_i.start) begin
            idx_prev_q <= '0;
            active_q   <= 1'b0;
        end else begin
            idx_prev_q <= idx;
            // index dropped, phase wrapped
            if (idx < idx_prev_q) begin
                active_q <= !active_q;
            end
        end
    end

    assign active_table_o = active_q;

    // ==========================================================================
    // sample tables
    // ==========================================================================

    // double buffer, host refills the idle one
    sample_t table_1 [1024];
    sample_t table_2 [1024];

    always_ff @(posedge clk_i) begin
        if (cmd_i.write_table && !cmd_i.table_addr[$bits(tab_addr_t)-1]) begin
            table_1[cmd_i.table_addr[$bits(tab_idx_t)-1:0]] <= cmd_i.pcm;
        end
    end

    always_ff @(posedge clk_i) begin
        if (cmd_i.write_table && cmd_i.table_addr[$bits(tab_addr_t)-1]) begin
            table_2[cmd_i.table_addr[$bits(tab_idx_t)-1:0]] <= cmd_i.pcm;
        end
    end

    // ==========================================================================
    // output register
    // ==========================================================================

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wave_o <= '0;
        end else if (cmd_i.enable) begin
            wave_o <= active_q ? table_2[idx] : table_1[idx];
        end else begin
            // muted voice
            wave_o <= '0;
        end
    end

    // disabled voice is silent on the next sample
    a_mute_when_disabled : assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        !cmd_i.enable |=> (wave_o == '0)
    );

endmodule : custom_wave_generator

// ==== hw/voice_ctrl.sv ====
`timescale 1ns/1ps

module voice_ctrl
    import synth_pkg::*;
#(
    parameter int NUM_VOICES = 4
) (
    input  logic       clk_i,
    input  logic       rst_n_i,

    // host write port
    input  logic       wr_i,
    input  bus_addr_t  addr_i,
    input  bus_data_t  data_i,

    // one command bundle per voice
    output voice_cmd_t cmd_o [NUM_VOICES]
);

    // ==========================================================================
    // address decode
    // ==========================================================================

    region_e   region;
    voice_id_t voice_sel;
    logic      voice_ok;

    assign region    = region_e'(addr_i[REGION_MSB:REGION_LSB]);
    assign voice_sel = addr_i[VOICE_MSB:VOICE_LSB];
    // voices past NUM_VOICES are dropped
    assign voice_ok  = int'(voice_sel) < NUM_VOICES;

    // ==========================================================================
    // shared table write payload
    // ==========================================================================

    tab_addr_t tab_addr_q;
    sample_t   pcm_q;

    // captured on every table write
    // only the strobed voice picks it up
    always_ff @(posedge clk_i) begin
        if (wr_i && region == REGION_TABLE) begin
            tab_addr_q <= addr_i[$bits(tab_addr_t)-1:0];
            pcm_q      <= sample_t'(data_i[$bits(sample_t)-1:0]);
        end
    end

    // ==========================================================================
    // per-voice registers
    // ==========================================================================

    for (genvar v = 0; v < NUM_VOICES; v++) begin : g_voice

        logic   hit;
        logic   wr_tab_q;
        logic   start_q;
        logic   enable_q;
        phase_t step_q;

        // write aimed at this voice
        assign hit = wr_i && voice_ok && (int'(voice_sel) == v);

        always_ff @(posedge clk_i or negedge rst_n_i) begin
            if (!rst_n_i) begin
                wr_tab_q <= 1'b0;
                start_q  <= 1'b0;
                enable_q <= 1'b0;
                step_q   <= '0;
            end else begin
                // one-cycle pulses
                wr_tab_q <= hit && (region == REGION_TABLE);
                start_q  <= hit && (region == REGION_CTRL) && data_i[CTRL_START_BIT];
                // held levels
                if (hit && region == REGION_STEP) begin
                    step_q <= phase_t'(data_i);
                end
                if (hit && region == REGION_CTRL) begin
                    enable_q <= data_i[CTRL_ENABLE_BIT];
                end
            end
        end

        assign cmd_o[v] = '{
            write_table: wr_tab_q,
            table_addr:  tab_addr_q,
            pcm:         pcm_q,
            enable:      enable_q,
            start:       start_q,
            inc_step:    step_q
        };

        // a voice never gets a restart and a table write together
        a_no_start_and_write : assert property (
            @(posedge clk_i) disable iff (!rst_n_i)
            !(cmd_o[v].start && cmd_o[v].write_table)
        );

    end : g_voice

endmodule : voice_ctrl

// ==== hw/synth_pkg.sv ====
package synth_pkg;

    // ==========================================================================
    // data words
    // ==========================================================================

    // one signed pcm sample
    typedef logic signed [15:0] sample_t;
    // phase accumulator and step
    typedef logic [31:0] phase_t;
    // read index, top ten phase bits
    typedef logic [9:0] tab_idx_t;
    // write address, msb picks table 2
    typedef logic [10:0] tab_addr_t;

    // ==========================================================================
    // host bus and address map
    // ==========================================================================

    typedef logic [15:0] bus_addr_t;
    typedef logic [31:0] bus_data_t;

    // address fields
    localparam int REGION_MSB = 15;
    localparam int REGION_LSB = 14;
    localparam int VOICE_MSB  = 13;
    localparam int VOICE_LSB  = 11;
    localparam int VOICE_W    = VOICE_MSB - VOICE_LSB + 1;
    // 3-bit voice field caps the voice count at 8
    localparam int MAX_VOICES = 2 ** VOICE_W;

    typedef logic [VOICE_W-1:0] voice_id_t;

    typedef enum logic [1:0] {
        REGION_TABLE = 2'd0,
        REGION_STEP  = 2'd1,
        REGION_CTRL  = 2'd2
    } region_e;

    // control word bits
    localparam int CTRL_ENABLE_BIT = 0;
    localparam int CTRL_START_BIT  = 1;

    // per-voice command bundle
    typedef struct packed {
        logic      write_table;
        tab_addr_t table_addr;
        sample_t   pcm;
        logic      enable;
        logic      start;
        phase_t    inc_step;
    } voice_cmd_t;

endpackage : synth_pkg
